// File: verilog/rv32_settings.svh
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// Widths
`define XLEN            32
`define ALU_OP_W        5
`define CLASS_W         4
`define TYPE_W          8

// Base opcodes
`define OPC_LOAD        7'b0000011
`define OPC_OPIMM       7'b0010011
`define OPC_AUIPC       7'b0010111
`define OPC_STORE       7'b0100011
`define OPC_RTYPE       7'b0110011
`define OPC_LUI         7'b0110111
`define OPC_BRANCH      7'b1100011
`define OPC_JALR        7'b1100111
`define OPC_JAL         7'b1101111

`define FUNCT7_BASE     7'd0
`define FUNCT7_ALT      7'd32           // SUB and SRA
`define FUNCT7_MULDIV   7'd1

// M extension reuses the same funct3 slots
`define FUNCT3_ADD      3'd0
`define FUNCT3_SLL      3'd1
`define FUNCT3_SLT      3'd2
`define FUNCT3_SLTU     3'd3
`define FUNCT3_XOR      3'd4
`define FUNCT3_SR       3'd5
`define FUNCT3_OR       3'd6
`define FUNCT3_AND      3'd7

// ALU operation codes
`define OP_AND          5'd0
`define OP_OR           5'd1
`define OP_XOR          5'd2
`define OP_ADD          5'd3
`define OP_SUB          5'd4
`define OP_SLT          5'd5
`define OP_SLTU         5'd6
`define OP_SLL          5'd7
`define OP_SRL          5'd8
`define OP_SRA          5'd9
`define OP_LUI          5'd10
`define OP_MUL          5'd11
`define OP_MULH         5'd12
`define OP_MULHSU       5'd13
`define OP_MULHU        5'd14
`define OP_DIV          5'd15
`define OP_DIVU         5'd16
`define OP_REM          5'd17
`define OP_REMU         5'd18
`define OP_NULL         5'd31

// Instruction classes passed between stages
`define CLS_ILLEGAL     4'd0
`define CLS_LOAD        4'd1
`define CLS_STORE       4'd2
`define CLS_OPIMM       4'd3
`define CLS_AUIPC       4'd4
`define CLS_LUI         4'd5
`define CLS_RTYPE       4'd6
`define CLS_MULDIV      4'd7
`define CLS_BRANCH      4'd8
`define CLS_JAL         4'd9
`define CLS_JALR        4'd10

// Bit positions in instrType
`define TYP_DIVREM      7
`define TYP_LOAD        6
`define TYP_STORE       5
`define TYP_R           4
`define TYP_I           3
`define TYP_JAL         2
`define TYP_JALR        1
`define TYP_BRANCH      0

`endif

// File: verilog/rv32DecodePkg.sv
package rv32DecodePkg;

    // One instruction word, two field layouts
    typedef union packed
    {
        struct packed
        {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFormat;

        struct packed
        {
            logic [11:0] imm;      // Top 7 bits pick SRAI
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFormat;
    } instrWord;

endpackage

// File: verilog/opcodeClassify.sv
`timescale 1ns/1ps
`include "rv32_settings.svh"

module opcodeClassify
    import rv32DecodePkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    output logic                inReady,
    input  instrWord            instr,
    output logic                clsValid,
    input  logic                clsReady,
    output instrWord            clsWord,
    output logic [`CLASS_W-1:0] clsCode
);

    logic [`CLASS_W-1:0] nextCode;
    logic                take;

    assign inReady = !clsValid || clsReady;   // Empty or drained this edge
    assign take    = inValid && inReady;

    always_comb
    begin
        case (instr.rFormat.opcode)
            `OPC_LOAD:   nextCode = `CLS_LOAD;
            `OPC_STORE:  nextCode = `CLS_STORE;
            `OPC_OPIMM:  nextCode = `CLS_OPIMM;
            `OPC_AUIPC:  nextCode = `CLS_AUIPC;
            `OPC_LUI:    nextCode = `CLS_LUI;
            `OPC_BRANCH: nextCode = `CLS_BRANCH;
            `OPC_JAL:    nextCode = `CLS_JAL;
            `OPC_JALR:   nextCode = `CLS_JALR;
            `OPC_RTYPE:
            begin
                case (instr.rFormat.funct7)
                    `FUNCT7_BASE,
                    `FUNCT7_ALT:    nextCode = `CLS_RTYPE;
                    `FUNCT7_MULDIV: nextCode = `CLS_MULDIV;
                    default:        nextCode = `CLS_ILLEGAL;   // Unknown funct7
                endcase
            end
            default:     nextCode = `CLS_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            clsValid <= 1'b0;
        end
        else if (inReady)
        begin
            clsValid <= inValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            clsWord <= instr;
            clsCode <= nextCode;
        end
    end

    // Held item must not change until controlGen takes it
    assert property (@(posedge clk) disable iff (!rstN)
        clsValid && !clsReady |=> clsValid && $stable(clsWord) && $stable(clsCode))
    else $error("opcodeClassify: held item changed under stall");

endmodule

// File: verilog/controlGen.sv
`timescale 1ns/1ps
`include "rv32_settings.svh"

module controlGen
    import rv32DecodePkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 clsValid,
    output logic                 clsReady,
    input  instrWord             clsWord,
    input  logic [`CLASS_W-1:0]  clsCode,
    output logic                 outValid,
    input  logic                 outReady,
    output logic                 origA,
    output logic                 origB,
    output logic                 regWrite,
    output logic                 memWrite,
    output logic                 memRead,
    output logic [1:0]           mem2Reg,
    output logic [1:0]           origPc,
    output logic [`ALU_OP_W-1:0] aluOp,
    output logic [`TYPE_W-1:0]   instrType
);

    logic [2:0]           funct3;
    logic                 subSel;
    logic                 sraSel;
    logic [`ALU_OP_W-1:0] baseOp;
    logic [`ALU_OP_W-1:0] mulOp;
    logic [8:0]           nextCtrl;    // origA down to origPc
    logic [`ALU_OP_W-1:0] nextOp;
    logic [`TYPE_W-1:0]   nextType;
    logic                 take;

    assign clsReady = !outValid || outReady;
    assign take     = clsValid && clsReady;

    assign funct3 = clsWord.rFormat.funct3;
    assign subSel = (clsCode == `CLS_RTYPE) && (clsWord.rFormat.funct7 == `FUNCT7_ALT);
    assign sraSel = subSel ||
                    ((clsCode == `CLS_OPIMM) && (clsWord.iFormat.imm[11:5] == `FUNCT7_ALT));

    always_comb
    begin
        case (funct3)
            `FUNCT3_ADD:  baseOp = subSel ? `OP_SUB : `OP_ADD;
            `FUNCT3_SLL:  baseOp = `OP_SLL;
            `FUNCT3_SLT:  baseOp = `OP_SLT;
            `FUNCT3_SLTU: baseOp = `OP_SLTU;
            `FUNCT3_XOR:  baseOp = `OP_XOR;
            `FUNCT3_SR:   baseOp = sraSel ? `OP_SRA : `OP_SRL;
            `FUNCT3_OR:   baseOp = `OP_OR;
            default:      baseOp = `OP_AND;
        endcase
    end

    always_comb
    begin
        case (funct3)
            `FUNCT3_ADD:  mulOp = `OP_MUL;
            `FUNCT3_SLL:  mulOp = `OP_MULH;
            `FUNCT3_SLT:  mulOp = `OP_MULHSU;
            `FUNCT3_SLTU: mulOp = `OP_MULHU;
            `FUNCT3_XOR:  mulOp = `OP_DIV;
            `FUNCT3_SR:   mulOp = `OP_DIVU;
            `FUNCT3_OR:   mulOp = `OP_REM;
            default:      mulOp = `OP_REMU;
        endcase
    end

    always_comb
    begin
        nextCtrl = '0;
        nextOp   = `OP_ADD;
        nextType = '0;
        case (clsCode)
            `CLS_LOAD:
            begin
                nextCtrl = 9'b01101_10_00;
                nextType[`TYP_LOAD] = 1'b1;
            end
            `CLS_STORE:
            begin
                nextCtrl = 9'b01010_00_00;
                nextType[`TYP_STORE] = 1'b1;
            end
            `CLS_OPIMM:
            begin
                nextCtrl = 9'b01100_00_00;
                nextOp   = baseOp;
                nextType[`TYP_I] = 1'b1;
            end
            `CLS_AUIPC:
            begin
                nextCtrl = 9'b11100_00_00;   // PC as operand A
                nextType[`TYP_I] = 1'b1;
            end
            `CLS_LUI:
            begin
                nextCtrl = 9'b01100_00_00;
                nextOp   = `OP_LUI;
                nextType[`TYP_I] = 1'b1;
            end
            `CLS_RTYPE:
            begin
                nextCtrl = 9'b00100_00_00;
                nextOp   = baseOp;
                nextType[`TYP_R] = 1'b1;
            end
            `CLS_MULDIV:
            begin
                nextCtrl = 9'b00100_00_00;
                nextOp   = mulOp;
                nextType[`TYP_R]      = 1'b1;
                nextType[`TYP_DIVREM] = 1'b1;
            end
            `CLS_BRANCH:
            begin
                nextCtrl = 9'b00000_00_01;
                nextType[`TYP_BRANCH] = 1'b1;
            end
            `CLS_JALR:
            begin
                nextCtrl = 9'b00100_01_11;   // Link write and PC from rs1
                nextType[`TYP_JALR] = 1'b1;
            end
            `CLS_JAL:
            begin
                nextCtrl = 9'b00100_01_10;
                nextType[`TYP_JAL] = 1'b1;
            end
            default:  nextOp = `OP_NULL;       // Illegal gives an empty word
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
        end
        else if (clsReady)
        begin
            outValid <= clsValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            {origA, origB, regWrite, memWrite, memRead, mem2Reg, origPc} <= nextCtrl;
            aluOp     <= nextOp;
            instrType <= nextType;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable({origA, origB, regWrite, memWrite,
            memRead, mem2Reg, origPc, aluOp, instrType}))
    else $error("controlGen: output changed under stall");

    // NULL only for words that opcodeClassify marked illegal
    assert property (@(posedge clk) disable iff (!rstN)
        take |=> ((aluOp == `OP_NULL) == ($past(clsCode) == `CLS_ILLEGAL)))
    else $error("controlGen: aluOp NULL does not match illegal class");

endmodule

// File: verilog/decodePipe.sv
`timescale 1ns/1ps
`include "rv32_settings.svh"

module decodePipe
    import rv32DecodePkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    output logic                 inReady,
    input  instrWord             instr,
    output logic                 outValid,
    input  logic                 outReady,
    output logic                 origA,
    output logic                 origB,
    output logic                 regWrite,
    output logic                 memWrite,
    output logic                 memRead,
    output logic [1:0]           mem2Reg,
    output logic [1:0]           origPc,
    output logic [`ALU_OP_W-1:0] aluOp,
    output logic [`TYPE_W-1:0]   instrType
);

    logic                clsValid;
    logic                clsReady;
    instrWord            clsWord;
    logic [`CLASS_W-1:0] clsCode;

    opcodeClassify i_opcodeClassify (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .clsValid (clsValid),
        .clsReady (clsReady),
        .clsWord  (clsWord),
        .clsCode  (clsCode)
    );

    controlGen i_controlGen (
        .clk       (clk),
        .rstN      (rstN),
        .clsValid  (clsValid),
        .clsReady  (clsReady),
        .clsWord   (clsWord),
        .clsCode   (clsCode),
        .outValid  (outValid),
        .outReady  (outReady),
        .origA     (origA),
        .origB     (origB),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .mem2Reg   (mem2Reg),
        .origPc    (origPc),
        .aluOp     (aluOp),
        .instrType (instrType)
    );

endmodule

// File: verif/decodePipeTests.svh
function automatic instrWord buildWord(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [6:0] opc);
    instrWord w;
    w = {f7, 5'd5, 5'd6, f3, 5'd7, opc};   // f7 doubles as imm[11:5]
    return w;
endfunction

// Holds valid and data until the scoreboard sees the transfer
task automatic sendInstr(input instrWord w);
    int seen;
    seen = acceptCount;
    @(negedge clk);
    inValid = 1'b1;
    instr   = w;
    while (acceptCount == seen)
        @(negedge clk);
    inValid = 1'b0;
endtask

task automatic waitDrain();
    int n;
    n = 0;
    while (expQ.size() != 0 && n < 10)
    begin
        @(negedge clk);
        n++;
    end
    if (expQ.size() != 0)
    begin
        $display("At %0t: %0d accepted instructions never came out", $time, expQ.size());
        protocolErrors++;
        expQ.delete();
        cycQ.delete();
    end
endtask

task automatic checkAfterReset();
    @(negedge clk);
    checkField("outValid", 8'd0, outValid);
    checkField("inReady", 8'd1, inReady);
endtask

task automatic testClasses();
    sendInstr(buildWord(7'd0, 3'd2, `OPC_LOAD));
    sendInstr(buildWord(7'd0, 3'd2, `OPC_STORE));
    sendInstr(buildWord(7'd12, 3'd0, `OPC_AUIPC));
    sendInstr(buildWord(7'd99, 3'd3, `OPC_LUI));
    sendInstr(buildWord(7'd0, 3'd1, `OPC_BRANCH));
    sendInstr(buildWord(7'd64, 3'd0, `OPC_JAL));
    sendInstr(buildWord(7'd0, 3'd0, `OPC_JALR));
    waitDrain();
endtask

task automatic testAluOps();
    for (int f = 0; f < 8; f++)
    begin
        sendInstr(buildWord(7'd0, f[2:0], `OPC_OPIMM));
        sendInstr(buildWord(7'd32, f[2:0], `OPC_OPIMM));
        sendInstr(buildWord(7'd0, f[2:0], `OPC_RTYPE));
        sendInstr(buildWord(7'd32, f[2:0], `OPC_RTYPE));
    end
    sendInstr(buildWord(7'h15, 3'd5, `OPC_OPIMM));   // Odd top bits stay SRL
    waitDrain();
endtask

task automatic testMulDiv();
    for (int f = 0; f < 8; f++)
        sendInstr(buildWord(7'd1, f[2:0], `OPC_RTYPE));
    waitDrain();
endtask

task automatic testIllegal();
    sendInstr(buildWord(7'd0, 3'd0, 7'b1111111));
    sendInstr(buildWord(7'd0, 3'd0, 7'b0000000));
    sendInstr(buildWord(7'h40, 3'd0, `OPC_RTYPE));
    sendInstr(buildWord(7'h02, 3'd5, `OPC_RTYPE));
    waitDrain();
endtask

function automatic instrWord randomInstr();
    instrWord   w;
    logic [3:0] sel;
    logic [1:0] f7Pick;
    logic [6:0] f7;
    w      = randBits(32);
    sel    = 4'(randBits(4));
    f7Pick = 2'(randBits(2));
    case (f7Pick)
        2'd0:    f7 = 7'd0;
        2'd1:    f7 = 7'd32;
        2'd2:    f7 = 7'd1;
        default: f7 = w.rFormat.funct7;
    endcase
    case (sel)
        4'd0:    w.rFormat.opcode = `OPC_LOAD;
        4'd1:    w.rFormat.opcode = `OPC_STORE;
        4'd2:    w.rFormat.opcode = `OPC_OPIMM;
        4'd3:    w.rFormat.opcode = `OPC_AUIPC;
        4'd4:    w.rFormat.opcode = `OPC_LUI;
        4'd5:    w.rFormat.opcode = `OPC_BRANCH;
        4'd6:    w.rFormat.opcode = `OPC_JAL;
        4'd7:    w.rFormat.opcode = `OPC_JALR;
        4'd8:    w.rFormat.opcode = w.rFormat.opcode;   // Mostly illegal
        default: w.rFormat.opcode = `OPC_RTYPE;
    endcase
    if (w.rFormat.opcode == `OPC_RTYPE || w.rFormat.opcode == `OPC_OPIMM)
        w.rFormat.funct7 = f7;
    return w;
endfunction

// Random valid and back-pressure, scoreboard checks order and content
task automatic randomStream();
    int target;
    int seen;
    target        = acceptCount + RANDOM_INSTR;
    seen          = acceptCount;
    strictLatency = 1'b0;
    while (acceptCount < target)
    begin
        @(negedge clk);
        outReady = (randBits(2) != 0);
        if (!inValid || acceptCount != seen)
        begin
            seen    = acceptCount;
            inValid = (acceptCount < target) && (randBits(1) != 0);
            instr   = randomInstr();
        end
    end
    inValid  = 1'b0;
    outReady = 1'b1;
    waitDrain();
endtask

// File: verif/decodePipeTb.sv
`timescale 1ns/1ps
`include "rv32_settings.svh"

module decodePipeTb
    import rv32DecodePkg::*;
();

    localparam int DIRECTED_INSTR  = 52;
    localparam int RANDOM_INSTR    = 200;
    localparam int WATCHDOG_CYCLES = (DIRECTED_INSTR + RANDOM_INSTR) * 20;

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    logic                 inReady;
    instrWord             instr;
    logic                 outValid;
    logic                 outReady;
    logic                 origA;
    logic                 origB;
    logic                 regWrite;
    logic                 memWrite;
    logic                 memRead;
    logic [1:0]           mem2Reg;
    logic [1:0]           origPc;
    logic [`ALU_OP_W-1:0] aluOp;
    logic [`TYPE_W-1:0]   instrType;

    logic [21:0] expQ [$];     // {ctrl bits, aluOp, instrType}
    int          cycQ [$];     // Acceptance cycle per entry
    logic [21:0] expWord;
    int          acceptCycle;
    int          cycle;
    int          acceptCount;
    int          valueErrors;
    int          protocolErrors;
    logic        strictLatency;
    logic [31:0] lfsr;

    decodePipe i_decodePipe (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .instr     (instr),
        .outValid  (outValid),
        .outReady  (outReady),
        .origA     (origA),
        .origB     (origB),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .mem2Reg   (mem2Reg),
        .origPc    (origPc),
        .aluOp     (aluOp),
        .instrType (instrType)
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hA3000000 : 32'h0);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected control word straight from the opcode and function fields
    function automatic logic [21:0] refCtrl(input instrWord w);
        logic [`ALU_OP_W-1:0] aluTab [8];
        logic [`ALU_OP_W-1:0] mulTab [8];
        logic [8:0]           c;   // origA origB regWrite memWrite memRead mem2Reg origPc
        logic [`ALU_OP_W-1:0] op;
        logic [`TYPE_W-1:0]   t;
        logic [2:0]           f3;
        logic [6:0]           f7;
        aluTab = '{`OP_ADD, `OP_SLL, `OP_SLT, `OP_SLTU, `OP_XOR, `OP_SRL, `OP_OR, `OP_AND};
        mulTab = '{`OP_MUL, `OP_MULH, `OP_MULHSU, `OP_MULHU, `OP_DIV, `OP_DIVU, `OP_REM,
                   `OP_REMU};
        c  = '0;
        t  = '0;
        op = `OP_ADD;
        f3 = w.rFormat.funct3;
        f7 = w.rFormat.funct7;
        case (w.rFormat.opcode)
            `OPC_LOAD:   {c, t} = {9'b01101_10_00, 8'h40};
            `OPC_STORE:  {c, t} = {9'b01010_00_00, 8'h20};
            `OPC_OPIMM:  {c, t} = {9'b01100_00_00, 8'h08};
            `OPC_AUIPC:  {c, t} = {9'b11100_00_00, 8'h08};
            `OPC_LUI:    {c, t} = {9'b01100_00_00, 8'h08};
            `OPC_BRANCH: {c, t} = {9'b00000_00_01, 8'h01};
            `OPC_JALR:   {c, t} = {9'b00100_01_11, 8'h02};
            `OPC_JAL:    {c, t} = {9'b00100_01_10, 8'h04};
            `OPC_RTYPE:  {c, t} = {9'b00100_00_00, (f7 == 7'd1) ? 8'h90 : 8'h10};
            default:     op = `OP_NULL;
        endcase
        if (w.rFormat.opcode == `OPC_LUI)
            op = `OP_LUI;
        if (w.rFormat.opcode == `OPC_OPIMM)
            op = (f3 == 3'd5 && w.iFormat.imm[11:5] == 7'd32) ? `OP_SRA : aluTab[f3];
        if (w.rFormat.opcode == `OPC_RTYPE)
        begin
            if (f7 == 7'd1)
                op = mulTab[f3];
            else if (f7 == 7'd32 && f3 == 3'd0)
                op = `OP_SUB;
            else if (f7 == 7'd32 && f3 == 3'd5)
                op = `OP_SRA;
            else if (f7 == 7'd0 || f7 == 7'd32)
                op = aluTab[f3];
            else
            begin
                {c, t} = '0;   // Bad funct7
                op     = `OP_NULL;
            end
        end
        return {c, op, t};
    endfunction

    task automatic checkField(input string name, input logic [7:0] expV, input logic [7:0] actV);
        if (expV !== actV)
        begin
            $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expV, actV);
            valueErrors++;
        end
    endtask

    task automatic compareOutputs(input logic [21:0] e);
        checkField("origA", e[21], origA);
        checkField("origB", e[20], origB);
        checkField("regWrite", e[19], regWrite);
        checkField("memWrite", e[18], memWrite);
        checkField("memRead", e[17], memRead);
        checkField("mem2Reg", e[16:15], mem2Reg);
        checkField("origPc", e[14:13], origPc);
        checkField("aluOp", e[12:8], aluOp);
        checkField("instrType", e[7:0], instrType);
    endtask

    // Scoreboard, pops before pushing so same-edge entries never match
    always @(posedge clk)
    begin
        if (rstN)
        begin
            cycle++;
            if (outValid && outReady)
            begin
                if (expQ.size() == 0)
                begin
                    $display("At %0t: output transfer with no instruction pending", $time);
                    protocolErrors++;
                end
                else
                begin
                    expWord     = expQ.pop_front();
                    acceptCycle = cycQ.pop_front();
                    compareOutputs(expWord);
                    if (strictLatency && (cycle - acceptCycle != 2))
                    begin
                        $display("At %0t: control word came %0d cycles after acceptance, not 2",
                                 $time, cycle - acceptCycle);
                        protocolErrors++;
                    end
                end
            end
            if (inValid && inReady)
            begin
                expQ.push_back(refCtrl(instr));
                cycQ.push_back(cycle);
                acceptCount++;
            end
        end
    end

    `include "decodePipeTests.svh"

    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        clk            = 1'b0;
        rstN           = 1'b0;
        inValid        = 1'b0;
        instr          = '0;
        outReady       = 1'b1;
        lfsr           = 32'h6a8a07c1;
        strictLatency  = 1'b1;
        cycle          = 0;
        acceptCount    = 0;
        valueErrors    = 0;
        protocolErrors = 0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        checkAfterReset();
        testClasses();
        testAluOps();
        testMulDiv();
        testIllegal();
        randomStream();
        $display("Value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
+incdir+verif
verilog/rv32DecodePkg.sv
verilog/opcodeClassify.sv
verilog/controlGen.sv
verilog/decodePipe.sv
verif/decodePipeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module decodePipeTb \
    --Mdir obj_dir -o simv > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 ; cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0
